// File: extern_handle.sv
// Length must not exceed BUFF_SIZE and the host must accept each load word as it appears

module extern_handle
	import tpu_data_pkg::*;
	import tpu_ctrl_pkg::*;
#(
	parameter int BUFF_SIZE = 16
)(
	input  logic     clock,
	input  logic     reset,
	input  logic     in_req,
	input  data_t    in_data,
	input  logic     in_rls,
	output logic     out_req,
	output data_t    out_data,
	output logic     out_rls,
	output logic     ld_req,
	output address_t ld_length,
	output stride_t  ld_stride,
	output address_t ld_base,
	input  logic     ld_grant,
	input  data_t    ld_data,
	input  logic     ld_valid,
	input  logic     ld_term,
	output logic     st_req,
	output address_t st_length,
	output stride_t  st_stride,
	output address_t st_base,
	input  logic     st_grant,
	output data_t    st_data,
	input  logic     st_term,
	output logic     mem_rls
);

	localparam int WIDTH_BUFF = $clog2(BUFF_SIZE);

	fsm_extern_t    serv_state;
	fsm_extern_st_t st_state;
	fsm_extern_ld_t ld_state;

	logic     is_load;			// Bit 31 of the stride word
	stride_t  r_stride;
	address_t r_length;
	address_t r_base;
	address_t delivered;		// Load words handed to the host

	logic                config_set;
	logic                st_take;
	logic                st_drain;
	logic                ld_take;
	logic                buf_we;
	logic                buf_re;
	logic                buf_full;
	logic                buf_empty;
	data_t               buf_wr_data;
	data_t               buf_rd_data;
	logic [WIDTH_BUFF:0] buf_count;

	////////////////////////////////////////
	// Memory-side config

	assign config_set = serv_state == FSM_EXTERN_RECV_SET;

	assign ld_req    = config_set & is_load;
	assign ld_length = r_length;
	assign ld_stride = r_stride;
	assign ld_base   = r_base;

	assign st_req    = (config_set & ~is_load) | st_drain;	// Config pulse, then data strobes
	assign st_length = r_length;
	assign st_stride = r_stride;
	assign st_base   = r_base;
	assign st_data   = buf_rd_data;

	// Abort only reaches memory while a transfer is live
	assign mem_rls = in_rls & ((st_state != FSM_EXTERN_ST_INIT) | (ld_state != FSM_EXTERN_LD_INIT));

	////////////////////////////////////////
	// Buffer steering

	assign st_take  = in_req & ((st_state == FSM_EXTERN_ST_BUFF) | (st_state == FSM_EXTERN_ST_RUN));
	assign st_drain = (st_state == FSM_EXTERN_ST_RUN) & ~buf_empty;
	assign ld_take  = ld_valid & (ld_state == FSM_EXTERN_LD_RUN);

	assign buf_we      = (st_take | ld_take) & ~buf_full;
	assign buf_re      = st_drain | out_req;
	assign buf_wr_data = is_load ? ld_data : in_data;

	assign out_req  = (ld_state == FSM_EXTERN_LD_RUN) & (buf_count != '0);
	assign out_data = buf_rd_data;
	assign out_rls  = out_req & (delivered == r_length - 1'b1);

	// Header capture, one field per host word
	always_ff @(posedge clock) begin
		if (in_req && serv_state == FSM_EXTERN_INIT) begin
			r_stride <= stride_t'(in_data);
		end
		if (in_req && serv_state == FSM_EXTERN_RECV_LENGTH) begin
			r_length <= address_t'(in_data);
		end
		if (in_req && serv_state == FSM_EXTERN_RECV_BASE) begin
			r_base <= address_t'(in_data);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			is_load   <= 1'b0;
			delivered <= '0;
		end else begin
			if (in_req && serv_state == FSM_EXTERN_INIT) begin
				is_load <= in_data[WIDTH_DATA-1];
			end
			if (config_set) begin
				delivered <= '0;
			end else if (out_req) begin
				delivered <= delivered + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Controllers

	always_ff @(posedge clock) begin
		if (reset || in_rls) begin
			serv_state <= FSM_EXTERN_INIT;
		end else begin
			unique case (serv_state)
				FSM_EXTERN_INIT:        if (in_req) serv_state <= FSM_EXTERN_RECV_LENGTH;
				FSM_EXTERN_RECV_LENGTH: if (in_req) serv_state <= FSM_EXTERN_RECV_BASE;
				FSM_EXTERN_RECV_BASE:   if (in_req) serv_state <= FSM_EXTERN_RECV_SET;
				FSM_EXTERN_RECV_SET:    serv_state <= FSM_EXTERN_RUN;
				FSM_EXTERN_RUN:         if (ld_term || st_term) serv_state <= FSM_EXTERN_INIT;
				default:                serv_state <= FSM_EXTERN_INIT;
			endcase
		end
	end

	// Store enters BUFF with the base word so a data word in RECV_SET is kept
	always_ff @(posedge clock) begin
		if (reset || in_rls) begin
			st_state <= FSM_EXTERN_ST_INIT;
		end else begin
			unique case (st_state)
				FSM_EXTERN_ST_INIT: begin
					if (in_req && serv_state == FSM_EXTERN_RECV_BASE && !is_load) begin
						st_state <= FSM_EXTERN_ST_BUFF;
					end
				end
				FSM_EXTERN_ST_BUFF: if (st_grant) st_state <= FSM_EXTERN_ST_RUN;
				FSM_EXTERN_ST_RUN:  if (st_term) st_state <= FSM_EXTERN_ST_INIT;
				default:            st_state <= FSM_EXTERN_ST_INIT;
			endcase
		end
	end

	// Load stays in RUN until the last word leaves, after the service is done
	always_ff @(posedge clock) begin
		if (reset || in_rls) begin
			ld_state <= FSM_EXTERN_LD_INIT;
		end else begin
			unique case (ld_state)
				FSM_EXTERN_LD_INIT: if (ld_req) ld_state <= FSM_EXTERN_LD_WAIT;
				FSM_EXTERN_LD_WAIT: if (ld_grant) ld_state <= FSM_EXTERN_LD_RUN;
				FSM_EXTERN_LD_RUN:  if (out_rls) ld_state <= FSM_EXTERN_LD_INIT;
				default:            ld_state <= FSM_EXTERN_LD_INIT;
			endcase
		end
	end

	ring_buffer #(
		.BUFF_SIZE (BUFF_SIZE)
	) ring_buffer_inst (
		.clock   (clock),
		.reset   (reset),
		.we      (buf_we),
		.re      (buf_re),
		.clear   (in_rls),		// Abort drops buffered words
		.wr_data (buf_wr_data),
		.rd_data (buf_rd_data),
		.full    (buf_full),
		.empty   (buf_empty),
		.count   (buf_count)
	);

endmodule

// File: extern_port_top.sv
// Single host port with one data memory; one transfer at a time, length at most BUFF_SIZE

module extern_port_top
	import tpu_data_pkg::*;
#(
	parameter int BUFF_SIZE = 16,
	parameter int MEM_DEPTH = 256
)(
	input  logic  clock,
	input  logic  reset,
	input  logic  in_req,
	input  data_t in_data,
	input  logic  in_rls,
	output logic  out_req,
	output data_t out_data,
	output logic  out_rls
);

	// Load group
	logic     ld_req;
	address_t ld_length;
	stride_t  ld_stride;
	address_t ld_base;
	logic     ld_grant;
	data_t    ld_data;
	logic     ld_valid;
	logic     ld_term;

	// Store group
	logic     st_req;
	address_t st_length;
	stride_t  st_stride;
	address_t st_base;
	logic     st_grant;
	data_t    st_data;
	logic     st_term;

	logic     mem_rls;

	extern_handle #(
		.BUFF_SIZE (BUFF_SIZE)
	) extern_handle_inst (
		.clock     (clock),
		.reset     (reset),
		.in_req    (in_req),
		.in_data   (in_data),
		.in_rls    (in_rls),
		.out_req   (out_req),
		.out_data  (out_data),
		.out_rls   (out_rls),
		.ld_req    (ld_req),
		.ld_length (ld_length),
		.ld_stride (ld_stride),
		.ld_base   (ld_base),
		.ld_grant  (ld_grant),
		.ld_data   (ld_data),
		.ld_valid  (ld_valid),
		.ld_term   (ld_term),
		.st_req    (st_req),
		.st_length (st_length),
		.st_stride (st_stride),
		.st_base   (st_base),
		.st_grant  (st_grant),
		.st_data   (st_data),
		.st_term   (st_term),
		.mem_rls   (mem_rls)
	);

	strided_mem_access #(
		.MEM_DEPTH (MEM_DEPTH)
	) strided_mem_access_inst (
		.clock     (clock),
		.reset     (reset),
		.ld_req    (ld_req),
		.ld_length (ld_length),
		.ld_stride (ld_stride),
		.ld_base   (ld_base),
		.ld_grant  (ld_grant),
		.ld_data   (ld_data),
		.ld_valid  (ld_valid),
		.ld_term   (ld_term),
		.st_req    (st_req),
		.st_length (st_length),
		.st_stride (st_stride),
		.st_base   (st_base),
		.st_grant  (st_grant),
		.st_data   (st_data),
		.st_term   (st_term),
		.mem_rls   (mem_rls)
	);

endmodule

// File: flist.f
tpu_data_pkg.sv
tpu_ctrl_pkg.sv
ring_buffer.sv
strided_mem_access.sv
extern_handle.sv
extern_port_top.sv
tb_extern_port.sv

// File: ring_buffer.sv
// BUFF_SIZE must be at least 2; writes while full and reads while empty are dropped, clear wins

module ring_buffer
	import tpu_data_pkg::*;
#(
	parameter int BUFF_SIZE = 16
)(
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       we,
	input  logic                       re,
	input  logic                       clear,
	input  data_t                      wr_data,
	output data_t                      rd_data,
	output logic                       full,
	output logic                       empty,
	output logic [$clog2(BUFF_SIZE):0] count
);

	localparam int WIDTH_BUFF = $clog2(BUFF_SIZE);

	data_t                 mem [BUFF_SIZE];
	logic [WIDTH_BUFF-1:0] wr_ptr;
	logic [WIDTH_BUFF-1:0] rd_ptr;
	logic                  do_wr;
	logic                  do_rd;

	assign full    = count == (WIDTH_BUFF+1)'(BUFF_SIZE);
	assign empty   = count == '0;
	assign do_wr   = we & ~full;
	assign do_rd   = re & ~empty;
	assign rd_data = mem[rd_ptr];		// Oldest word

	always_ff @(posedge clock) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// Pointers wrap at BUFF_SIZE, which need not be a power of two
	always_ff @(posedge clock) begin
		if (reset || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == WIDTH_BUFF'(BUFF_SIZE-1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == WIDTH_BUFF'(BUFF_SIZE-1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + (WIDTH_BUFF+1)'(do_wr) - (WIDTH_BUFF+1)'(do_rd);
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_extern_port \
	-f flist.f \
	-o sim_extern_port

./obj_dir/sim_extern_port > sim.log 2>&1
cat sim.log

if grep -q "All tests passed!" sim.log; then
	exit 0
else
	exit 1
fi

// File: strided_mem_access.sv
// Length must be at least 1 and MEM_DEPTH at most 65536; a config request is only taken when idle

module strided_mem_access
	import tpu_data_pkg::*;
	import tpu_ctrl_pkg::*;
#(
	parameter int MEM_DEPTH = 256
)(
	input  logic     clock,
	input  logic     reset,
	input  logic     ld_req,
	input  address_t ld_length,
	input  stride_t  ld_stride,
	input  address_t ld_base,
	output logic     ld_grant,
	output data_t    ld_data,
	output logic     ld_valid,
	output logic     ld_term,
	input  logic     st_req,
	input  address_t st_length,
	input  stride_t  st_stride,
	input  address_t st_base,
	output logic     st_grant,
	input  data_t    st_data,
	output logic     st_term,
	input  logic     mem_rls
);

	localparam int WIDTH_MEM = $clog2(MEM_DEPTH);

	data_t                mem [MEM_DEPTH];
	fsm_mem_t             state;
	logic                 is_load;
	address_t             r_length;
	stride_t              r_stride;
	logic [WIDTH_MEM-1:0] addr;
	address_t             done_cnt;		// Words issued so far
	logic                 rd_issue;
	logic                 wr_issue;
	logic                 last;
	logic [WIDTH_ADDR:0]  addr_sum;

	assign ld_grant = (state == FSM_MEM_GRANT) & is_load;
	assign st_grant = (state == FSM_MEM_GRANT) & ~is_load;

	// Loads start reading in the grant cycle, stores write as words arrive
	assign rd_issue = is_load & (state != FSM_MEM_IDLE) & (done_cnt != r_length);
	assign wr_issue = ~is_load & (state == FSM_MEM_XFER) & st_req;
	assign last     = done_cnt == r_length - 1'b1;
	assign addr_sum = (WIDTH_ADDR+1)'(addr) + (WIDTH_ADDR+1)'(r_stride);

	////////////////////////////////////////
	// Control

	always_ff @(posedge clock) begin
		if (reset || mem_rls) begin
			state <= FSM_MEM_IDLE;
		end else begin
			unique case (state)
				FSM_MEM_IDLE:  if (ld_req || st_req) state <= FSM_MEM_GRANT;
				FSM_MEM_GRANT: state <= FSM_MEM_XFER;
				FSM_MEM_XFER:  if (done_cnt == r_length) state <= FSM_MEM_IDLE;
				default:       state <= FSM_MEM_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			is_load  <= 1'b0;
			done_cnt <= '0;
		end else if (state == FSM_MEM_IDLE) begin
			if (ld_req || st_req) begin
				is_load <= ld_req;
			end
			done_cnt <= '0;
		end else if (rd_issue || wr_issue) begin
			done_cnt <= done_cnt + 1'b1;
		end
	end

	// Config latch and address walk, wrapping modulo MEM_DEPTH
	always_ff @(posedge clock) begin
		if (state == FSM_MEM_IDLE && ld_req) begin
			r_length <= ld_length;
			r_stride <= ld_stride;
			addr     <= WIDTH_MEM'(ld_base % MEM_DEPTH);
		end else if (state == FSM_MEM_IDLE && st_req) begin
			r_length <= st_length;
			r_stride <= st_stride;
			addr     <= WIDTH_MEM'(st_base % MEM_DEPTH);
		end else if (rd_issue || wr_issue) begin
			addr <= WIDTH_MEM'(addr_sum % MEM_DEPTH);
		end
	end

	////////////////////////////////////////
	// Memory array

	always_ff @(posedge clock) begin
		if (wr_issue) begin
			mem[addr] <= st_data;
		end
		if (rd_issue) begin
			ld_data <= mem[addr];		// Synchronous read
		end
	end

	always_ff @(posedge clock) begin
		if (reset || mem_rls) begin
			ld_valid <= 1'b0;
			ld_term  <= 1'b0;
			st_term  <= 1'b0;
		end else begin
			ld_valid <= rd_issue;
			ld_term  <= rd_issue & last;
			st_term  <= wr_issue & last;	// One cycle after the final write
		end
	end

endmodule

// File: tb_extern_port.sv
// Checks run only when Verilator is built with --assert; random data uses a fixed seed

module tb_extern_port
	import tpu_data_pkg::*;
();

	localparam int BUFF_SIZE   = 16;
	localparam int MEM_DEPTH   = 256;
	localparam int TOTAL_WORDS = 128;		// Header-less words over all transfers
	localparam int CYCLE_LIMIT = 40 * TOTAL_WORDS + 2000;

	logic  clock;
	logic  reset;
	logic  in_req;
	data_t in_data;
	logic  in_rls;
	logic  out_req;
	data_t out_data;
	logic  out_rls;

	data_t model [int];		// Mirror of data memory, keyed by word address
	data_t words [$];		// Data for the next store
	int    seed;
	int    errors;
	int    errors_at_start;
	int    tests_run;
	int    tests_failed;
	int    cycle_count;

	extern_port_top #(
		.BUFF_SIZE (BUFF_SIZE),
		.MEM_DEPTH (MEM_DEPTH)
	) extern_port_top_inst (
		.clock    (clock),
		.reset    (reset),
		.in_req   (in_req),
		.in_data  (in_data),
		.in_rls   (in_rls),
		.out_req  (out_req),
		.out_data (out_data),
		.out_rls  (out_rls)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

	////////////////////////////////////////
	// Host driver

	task automatic send_word(input data_t word);
		@(posedge clock);
		#1;
		in_req  = 1'b1;
		in_data = word;
	endtask

	task automatic release_bus();
		@(posedge clock);
		#1;
		in_req  = 1'b0;
		in_data = '0;
	endtask

	// Stride word carries the load flag in bit 31
	task automatic send_header(input logic load, input int stride, input int len, input int base);
		send_word({load, 15'd0, stride_t'(stride)});
		send_word({16'd0, address_t'(len)});
		send_word({16'd0, address_t'(base)});
	endtask

	task automatic fill_random(input int len);
		words.delete();
		for (int i = 0; i < len; i++) begin
			words.push_back($random(seed));
		end
	endtask

	task automatic store_words(input int base, input int stride, input int len);
		int addr;
		int wait_cycles;
		send_header(1'b0, stride, len, base);
		for (int i = 0; i < len; i++) begin
			send_word(words[i]);
		end
		release_bus();
		wait_cycles = 0;
		do begin
			@(negedge clock);
			wait_cycles++;
		end while (extern_port_top_inst.st_term !== 1'b1 && wait_cycles < 40);
		assert (extern_port_top_inst.st_term === 1'b1) else begin
			$display("Store of %0d words at base %0d never reported completion", len, base);
			errors++;
		end
		addr = base % MEM_DEPTH;
		for (int i = 0; i < len; i++) begin
			model[addr] = words[i];
			addr = (addr + stride) % MEM_DEPTH;	// Wraps like the memory port
		end
	endtask

	task automatic load_and_check(input int base, input int stride, input int len);
		int addr;
		int got;
		int idle;
		send_header(1'b1, stride, len, base);
		release_bus();
		addr = base % MEM_DEPTH;
		got  = 0;
		idle = 0;
		while (got < len && idle < 40) begin
			@(negedge clock);
			if (out_req) begin
				assert (out_data == model[addr]) else begin
					$display("MISMATCH at %0t: word %0d from address %0d is %h, expected %h",
						$time, got, addr, out_data, model[addr]);
					errors++;
				end
				assert (out_rls == (got == len - 1)) else begin
					$display("MISMATCH at %0t: out_rls is %b on word %0d of %0d",
						$time, out_rls, got + 1, len);
					errors++;
				end
				addr = (addr + stride) % MEM_DEPTH;
				got++;
			end else begin
				idle++;
			end
		end
		assert (got == len) else begin
			$display("Load at base %0d returned only %0d of %0d words", base, got, len);
			errors++;
		end
		repeat (4) begin
			@(negedge clock);
			assert (!out_req && !out_rls) else begin
				$display("MISMATCH at %0t: output still active after the last word", $time);
				errors++;
			end
		end
	endtask

	// Takes three words, then aborts and expects the port to go quiet
	task automatic abort_load_midway(input int base, input int len);
		int got;
		int idle;
		send_header(1'b1, 1, len, base);
		release_bus();
		got  = 0;
		idle = 0;
		while (got < 3 && idle < 40) begin
			@(negedge clock);
			if (out_req) begin
				assert (out_data == model[(base + got) % MEM_DEPTH]) else begin
					$display("MISMATCH at %0t: word %0d before abort is %h", $time, got, out_data);
					errors++;
				end
				got++;
			end else begin
				idle++;
			end
		end
		@(posedge clock);
		#1;
		in_rls = 1'b1;
		@(posedge clock);
		#1;
		in_rls = 1'b0;
		for (int i = 0; i < 20; i++) begin
			@(negedge clock);
			assert (!out_req && !out_rls) else begin
				$display("MISMATCH at %0t: output active %0d cycles after abort", $time, i);
				errors++;
			end
		end
	endtask

	task automatic start_test();
		errors_at_start = errors;
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("PASS  %s", name);
		end else begin
			tests_failed++;
			$display("FAIL  %s", name);
		end
	endtask

	////////////////////////////////////////
	// Test sequence

	initial begin
		reset        = 1'b1;
		in_req       = 1'b0;
		in_data      = '0;
		in_rls       = 1'b0;
		seed         = 32'h1121;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		cycle_count  = 0;

		start_test();
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;
		repeat (6) begin
			@(negedge clock);
			assert (!out_req && !out_rls) else begin
				$display("MISMATCH at %0t: output active before any header", $time);
				errors++;
			end
		end
		report_test("reset leaves the host outputs idle");

		start_test();
		fill_random(8);
		store_words(16, 1, 8);
		load_and_check(16, 1, 8);
		report_test("unit-stride round trip");

		start_test();
		fill_random(13);
		store_words(40, 1, 13);		// Known background
		fill_random(5);
		store_words(40, 3, 5);
		load_and_check(40, 1, 13);
		report_test("strided store, unit-stride reload");

		start_test();
		fill_random(BUFF_SIZE);
		store_words(100, 1, BUFF_SIZE);
		load_and_check(100, 1, BUFF_SIZE);
		report_test("full-buffer length");

		start_test();
		fill_random(6);
		store_words(250, 7, 6);
		load_and_check(250, 7, 6);
		load_and_check(1, 7, 5);		// Wrapped words read back from low addresses
		report_test("address wrap");

		start_test();
		fill_random(8);
		store_words(60, 1, 8);
		abort_load_midway(60, 8);
		fill_random(8);
		store_words(120, 2, 8);
		load_and_check(120, 2, 8);
		report_test("abort, then round trip");

		$display("%0d tests run, %0d failed, %0d failing checks", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: tpu_ctrl_pkg.sv
// Controller state encodings only; one transfer in flight, no notify states

package tpu_ctrl_pkg;

	// Host service, one state per header word after the stride
	typedef enum logic [2:0] {
		FSM_EXTERN_INIT,
		FSM_EXTERN_RECV_LENGTH,
		FSM_EXTERN_RECV_BASE,
		FSM_EXTERN_RECV_SET,
		FSM_EXTERN_RUN
	} fsm_extern_t;

	// Store side of the handler
	typedef enum logic [1:0] {
		FSM_EXTERN_ST_INIT,
		FSM_EXTERN_ST_BUFF,		// Collecting host words, no grant yet
		FSM_EXTERN_ST_RUN
	} fsm_extern_st_t;

	// Load side of the handler
	typedef enum logic [1:0] {
		FSM_EXTERN_LD_INIT,
		FSM_EXTERN_LD_WAIT,		// Config sent, waiting for grant
		FSM_EXTERN_LD_RUN
	} fsm_extern_ld_t;

	// Data-memory port
	typedef enum logic [1:0] {
		FSM_MEM_IDLE,
		FSM_MEM_GRANT,
		FSM_MEM_XFER
	} fsm_mem_t;

endpackage

// File: tpu_data_pkg.sv
// Header fields use only the low 16 bits of a 32-bit host word, so addresses and lengths stop at 65535

package tpu_data_pkg;

	////////////////////////////////////////
	// Widths

	localparam int WIDTH_DATA   = 32;
	localparam int WIDTH_ADDR   = 16;
	localparam int WIDTH_STRIDE = 16;

	////////////////////////////////////////
	// Word types

	// One word on the host port or in data memory
	typedef logic [WIDTH_DATA-1:0]   data_t;

	// Word address or transfer length
	typedef logic [WIDTH_ADDR-1:0]   address_t;

	// Address step, the load/store flag in bit 31 never reaches it
	typedef logic [WIDTH_STRIDE-1:0] stride_t;

endpackage
